/* verilog.f */
hw/eeprom_pkg.sv
hw/eeprom_req_queue.sv
hw/eeprom_frame_seq.sv
hw/eeprom_bit_engine.sv
hw/eeprom_ctrl_top.sv
verif/eeprom_model.sv
verif/eeprom_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the EEPROM controller testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module eeprom_ctrl_tb \
    -f verilog.f \
    -o eeprom_sim

./obj_dir/eeprom_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

/* verif/eeprom_ctrl_tb.sv */
module eeprom_ctrl_tb
    import eeprom_pkg::*;
();

    localparam int QUARTER  = 2;
    localparam int PERIOD   = 40;
    localparam int N_TXN    = 60;
    localparam int FRAME_BT = 39; // read frame, in bit times
    localparam int LIMIT    = N_TXN * FRAME_BT * 4 * QUARTER * PERIOD + 200 * PERIOD;

    logic              CLK;
    logic              RESET;
    logic              req_valid;
    logic              req_ready;
    op_e               req_op;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic              rsp_valid;
    logic              rsp_ready;
    logic [DATA_W-1:0] rsp_rdata;
    logic              rsp_nack;
    logic              scl;
    logic              sda_oe;
    logic              slave_oe;
    logic              sda;
    logic              present;

    logic [DATA_W-1:0] ref_mem [2**ADDR_W];
    logic [8:0]        exp_q [$];
    logic [8:0]        exp;
    integer            seed;
    int                data_errors;
    int                bus_errors;
    int                other_errors;
    int                cyc = 0;
    logic              rst_d;
    logic              scl_q;
    logic              sda_q;
    logic              rsp_valid_q;
    logic              in_frame;
    logic [ADDR_W-1:0] a;

    assign sda = !sda_oe && !slave_oe; // wired-AND of both drivers

    eeprom_ctrl_top #(.QUARTER(QUARTER)) uut
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .rsp_nack  (rsp_nack),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda)
    );

    eeprom_model slave
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .present (present),
        .scl     (scl),
        .sda     (sda),
        .sda_oe  (slave_oe)
    );

    initial
    begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    initial
    begin
        #(LIMIT);
        $display("watchdog expired before all responses arrived");
        $display("errors: data %0d, bus %0d, other %0d", data_errors, bus_errors, other_errors);
        $display("Test failed");
        $finish;
    end

    // reset state
    always @(posedge CLK)
    begin
        cyc   <= cyc + 1;
        rst_d <= RESET;
        if ((RESET || rst_d) && cyc > 0)
        begin
            assert (scl == 1'b1 && sda_oe == 1'b0 && rsp_valid == 1'b0 && req_ready == 1'b1)
            else
            begin
                $display("** Error: reset state scl=%h sda_oe=%h rsp_valid=%h req_ready=%h",
                         scl, sda_oe, rsp_valid, req_ready);
                other_errors++;
            end
        end
    end

    // responses checked at the handshake
    always @(posedge CLK)
    begin
        if (!RESET && rsp_valid && rsp_ready)
        begin
            if (exp_q.size() == 0)
            begin
                $display("response arrived with no request outstanding");
                other_errors++;
            end
            else
            begin
                exp = exp_q.pop_front();
                assert (rsp_nack == exp[8])
                else
                begin
                    $display("** Error: rsp_nack = %h, expected %h", rsp_nack, exp[8]);
                    data_errors++;
                end
                assert (rsp_rdata == exp[7:0])
                else
                begin
                    $display("** Error: rsp_rdata = %h, expected %h", rsp_rdata, exp[7:0]);
                    data_errors++;
                end
            end
        end
    end

    // sda edges with scl high are starts and stops
    // data moves only between a start and a stop
    always @(posedge CLK)
    begin
        scl_q       <= scl;
        sda_q       <= sda;
        rsp_valid_q <= rsp_valid;
        if (RESET)
            in_frame <= 1'b0;
        else
        begin
            if (scl && scl_q && sda_q && !sda)
                in_frame <= 1'b1;
            if (scl && scl_q && !sda_q && sda)
            begin
                assert (in_frame)
                else
                begin
                    $display("SDA rose while SCL was high outside a frame");
                    bus_errors++;
                end
                in_frame <= 1'b0;
            end
            if (!scl && !scl_q && (sda != sda_q))
            begin
                assert (in_frame)
                else
                begin
                    $display("SDA moved while SCL was low outside a frame");
                    bus_errors++;
                end
            end
            if (rsp_valid && !rsp_valid_q)
            begin
                assert (!in_frame)
                else
                begin
                    $display("response raised before the frame ended with a stop");
                    bus_errors++;
                end
            end
        end
    end

    task automatic send_req(input op_e op, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data);
        @(negedge CLK);
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = data;
        while (!req_ready)
            @(negedge CLK);
        @(posedge CLK); // request taken here
        if (!present)
            exp_q.push_back({1'b1, 8'h00});
        else if (op == OP_WRITE)
        begin
            ref_mem[addr] = data;
            exp_q.push_back({1'b0, 8'h00});
        end
        else
            exp_q.push_back({1'b0, ref_mem[addr]});
        @(negedge CLK);
        req_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0)
            @(posedge CLK);
        @(posedge CLK);
    endtask

    initial
    begin
        seed         = 32'hee73_e6c4;
        data_errors  = 0;
        bus_errors   = 0;
        other_errors = 0;
        RESET        = 1'b1;
        req_valid    = 1'b0;
        req_op       = OP_WRITE;
        req_addr     = '0;
        req_wdata    = '0;
        rsp_ready    = 1'b1;
        present      = 1'b1;
        for (int i = 0; i < 2**ADDR_W; i++)
            ref_mem[i] = i[7:0] ^ {i[10:8], 5'b10110};
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        send_req(OP_WRITE, 11'h155, 8'ha7);
        send_req(OP_READ, 11'h155, 8'h00);
        send_req(OP_WRITE, 11'h6ab, 8'h3c);
        send_req(OP_READ, 11'h6ab, 8'h00);
        wait_drained();

        repeat (40)
        begin
            a = ADDR_W'($random(seed));
            send_req(($random(seed) & 1) ? OP_READ : OP_WRITE, a, DATA_W'($random(seed)));
        end
        wait_drained();

        present = 1'b0; // nobody answers
        send_req(OP_WRITE, 11'h155, 8'h11);
        send_req(OP_WRITE, 11'h7f0, 8'h22);
        send_req(OP_READ, 11'h6ab, 8'h00);
        wait_drained();
        present = 1'b1;
        send_req(OP_READ, 11'h155, 8'h00);
        wait_drained();

        @(negedge CLK);
        rsp_ready = 1'b0;
        send_req(OP_WRITE, 11'h321, 8'h5a);
        send_req(OP_READ, 11'h321, 8'h00);
        send_req(OP_READ, 11'h0ff, 8'h00);
        while (!rsp_valid)
            @(posedge CLK);
        repeat (8) @(negedge CLK);
        assert (!req_ready)
        else
        begin
            $display("** Error: req_ready = %h, expected %h with two requests queued",
                     req_ready, 1'b0);
            other_errors++;
        end
        fork
            send_req(OP_WRITE, 11'h4c2, 8'he1);
            begin
                repeat (12) @(negedge CLK);
                rsp_ready = 1'b1;
            end
        join
        wait_drained();

        $display("errors: data %0d, bus %0d, other %0d", data_errors, bus_errors, other_errors);
        if (data_errors + bus_errors + other_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* verif/eeprom_model.sv */
module eeprom_model
    import eeprom_pkg::*;
(
    input  logic CLK,
    input  logic RESET,
    input  logic present,
    input  logic scl,
    input  logic sda,
    output logic sda_oe
);

    typedef enum logic [2:0]
    {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_TX
    } mstate_e;

    logic [DATA_W-1:0]    mem [2**ADDR_W];
    mstate_e              state;
    mstate_e              after_ack;
    logic [3:0]           bitcnt;   // rising scl edges seen in this byte
    logic [DATA_W-1:0]    shreg;
    logic [DATA_W-1:0]    txbyte;
    logic [ADDR_W-1:0]    ptr;
    logic [HI_ADDR_W-1:0] hi;
    logic                 scl_q;
    logic                 sda_q;
    logic                 rise;
    logic                 fall;
    logic                 start;
    logic                 stop;

    assign rise  = scl && !scl_q;
    assign fall  = !scl && scl_q;
    assign start = scl && scl_q && sda_q && !sda;
    assign stop  = scl && scl_q && !sda_q && sda;

    initial
    begin
        for (int i = 0; i < 2**ADDR_W; i++)
            mem[i] = i[7:0] ^ {i[10:8], 5'b10110}; // every address bit counts
    end

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= M_IDLE;
            bitcnt <= 4'd0;
            sda_oe <= 1'b0;
            scl_q  <= 1'b1;
            sda_q  <= 1'b1;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (start)
            begin
                state  <= M_CTRL;
                bitcnt <= 4'd0;
                sda_oe <= 1'b0;
            end
            else if (stop)
            begin
                state  <= M_IDLE;
                sda_oe <= 1'b0;
            end
            else if (rise && state != M_IDLE)
            begin
                bitcnt <= bitcnt + 4'd1;
                if (state != M_TX && bitcnt < 4'd8)
                    shreg <= {shreg[DATA_W-2:0], sda};
            end
            else if (fall && state == M_TX)
            begin
                if (bitcnt == 4'd9)
                begin
                    state  <= M_IDLE; // master nack seen
                    sda_oe <= 1'b0;
                end
                else if (bitcnt == 4'd8)
                    sda_oe <= 1'b0;
                else
                    sda_oe <= !txbyte[3'(4'd7 - bitcnt)];
            end
            else if (fall && state != M_IDLE)
            begin
                if (bitcnt == 4'd8)
                begin
                    case (state)
                        M_CTRL:
                        begin
                            if (present && shreg[7:4] == DEV_CODE)
                            begin
                                sda_oe    <= 1'b1;
                                hi        <= shreg[3:1];
                                after_ack <= shreg[0] ? M_TX : M_ADDR;
                            end
                            else
                                state <= M_IDLE; // not for us
                        end
                        M_ADDR:
                        begin
                            sda_oe    <= 1'b1;
                            ptr       <= {hi, shreg};
                            after_ack <= M_WDATA;
                        end
                        default:
                        begin
                            sda_oe    <= 1'b1;
                            mem[ptr]  <= shreg;
                            ptr       <= ptr + 1'b1;
                            after_ack <= M_WDATA;
                        end
                    endcase
                end
                else if (bitcnt == 4'd9)
                begin
                    bitcnt <= 4'd0;
                    state  <= after_ack;
                    if (after_ack == M_TX)
                    begin
                        txbyte <= mem[ptr];
                        sda_oe <= !mem[ptr][7];
                    end
                    else
                        sda_oe <= 1'b0;
                end
            end
        end
    end

endmodule

/* hw/eeprom_ctrl_top.sv */
module eeprom_ctrl_top
    import eeprom_pkg::*;
#(
    parameter int QUARTER = 4
)
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              req_valid,
    output logic              req_ready,
    input  op_e               req_op,
    input  logic [ADDR_W-1:0] req_addr,
    input  logic [DATA_W-1:0] req_wdata,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output logic [DATA_W-1:0] rsp_rdata,
    output logic              rsp_nack,
    output logic              scl,
    output logic              sda_oe,
    input  logic              sda_in
);

    // queue to sequencer
    logic              q_valid;
    logic              q_ready;
    op_e               q_op;
    logic [ADDR_W-1:0] q_addr;
    logic [DATA_W-1:0] q_wdata;

    // sequencer to bit engine
    logic              sym_valid;
    logic              sym_ready;
    sym_e              sym_kind;
    logic [DATA_W-1:0] sym_byte;
    logic              done;
    logic              done_ack;
    logic [DATA_W-1:0] done_rx;

    eeprom_req_queue u_queue
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_op     (req_op),
        .in_addr   (req_addr),
        .in_wdata  (req_wdata),
        .out_valid (q_valid),
        .out_ready (q_ready),
        .out_op    (q_op),
        .out_addr  (q_addr),
        .out_wdata (q_wdata)
    );

    eeprom_frame_seq u_seq
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .q_valid   (q_valid),
        .q_ready   (q_ready),
        .q_op      (q_op),
        .q_addr    (q_addr),
        .q_wdata   (q_wdata),
        .sym_valid (sym_valid),
        .sym_ready (sym_ready),
        .sym_kind  (sym_kind),
        .sym_byte  (sym_byte),
        .done      (done),
        .done_ack  (done_ack),
        .done_rx   (done_rx),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .rsp_nack  (rsp_nack)
    );

    eeprom_bit_engine #(.QUARTER(QUARTER)) u_engine
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .sym_valid (sym_valid),
        .sym_ready (sym_ready),
        .sym_kind  (sym_kind),
        .sym_byte  (sym_byte),
        .done      (done),
        .done_ack  (done_ack),
        .done_rx   (done_rx),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

endmodule

/* hw/eeprom_bit_engine.sv */
module eeprom_bit_engine
    import eeprom_pkg::*;
#(
    parameter int QUARTER = 4
)
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              sym_valid,
    output logic              sym_ready,
    input  sym_e              sym_kind,
    input  logic [DATA_W-1:0] sym_byte,
    output logic              done,
    output logic              done_ack,
    output logic [DATA_W-1:0] done_rx,
    output logic              scl,
    output logic              sda_oe,
    input  logic              sda_in
);

    localparam int QW = (QUARTER > 1) ? $clog2(QUARTER) : 1;
    localparam logic [QW-1:0] Q_LAST = QW'(QUARTER - 1);

    // each bit: phase 0,1 scl low, phase 2,3 scl high
    // data moves on entry to phase 1, start/stop edges on entry to phase 3

    logic              busy;
    logic [QW-1:0]     qcnt;
    logic [1:0]        phase;
    logic [3:0]        bitcnt;   // 0..7 data, 8 is the ack slot
    sym_e              kind;
    logic [DATA_W-1:0] shreg;
    logic [DATA_W-1:0] rx;
    logic              ack_r;
    logic              quarter_end;
    logic              ack_slot;
    logic              last_bit;
    logic              sda_drive;

    assign sym_ready   = !busy;
    assign done_ack    = ack_r;
    assign done_rx     = rx;
    assign quarter_end = busy && (qcnt == Q_LAST);
    assign ack_slot    = (bitcnt == 4'd8);
    assign last_bit    = (kind == SYM_START) || (kind == SYM_STOP) || ack_slot;

    // sda level for the low half of the bit
    always_comb
    begin
        case (kind)
            SYM_START:   sda_drive = 1'b0; // release before the high edge
            SYM_STOP:    sda_drive = 1'b1; // hold low, released later
            SYM_TX_BYTE: sda_drive = !ack_slot && !shreg[DATA_W-1];
            default:     sda_drive = 1'b0; // rx bits and master nack
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy   <= 1'b0;
            qcnt   <= '0;
            phase  <= 2'd0;
            bitcnt <= 4'd0;
            scl    <= 1'b1;
            sda_oe <= 1'b0;
            done   <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (!busy)
            begin
                if (sym_valid)
                begin
                    busy   <= 1'b1;
                    qcnt   <= '0;
                    phase  <= 2'd0;
                    bitcnt <= 4'd0;
                    scl    <= 1'b0;
                end
            end
            else if (!quarter_end)
                qcnt <= qcnt + 1'b1;
            else
            begin
                qcnt  <= '0;
                phase <= phase + 2'd1;
                case (phase)
                    2'd0: sda_oe <= sda_drive;
                    2'd1: scl <= 1'b1;
                    2'd2:
                    begin
                        if (kind == SYM_START)
                            sda_oe <= 1'b1; // sda falls, scl high
                        else if (kind == SYM_STOP)
                            sda_oe <= 1'b0; // sda rises, scl high
                    end
                    default:
                    begin
                        if (last_bit)
                        begin
                            busy <= 1'b0; // scl stays high
                            done <= 1'b1;
                        end
                        else
                        begin
                            bitcnt <= bitcnt + 4'd1;
                            scl    <= 1'b0;
                        end
                    end
                endcase
            end
        end
    end

    // shift paths
    always_ff @(posedge CLK)
    begin
        if (!busy && sym_valid)
        begin
            kind  <= sym_kind;
            shreg <= sym_byte;
        end
        else if (quarter_end)
        begin
            if (phase == 2'd2)
            begin
                if (kind == SYM_TX_BYTE && ack_slot)
                    ack_r <= !sda_in; // low means acknowledged
                if (kind == SYM_RX_BYTE && !ack_slot)
                    rx <= {rx[DATA_W-2:0], sda_in};
            end
            if (phase == 2'd3 && kind == SYM_TX_BYTE)
                shreg <= {shreg[DATA_W-2:0], 1'b0}; // msb first
        end
    end

endmodule

/* hw/eeprom_frame_seq.sv */
module eeprom_frame_seq
    import eeprom_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              q_valid,
    output logic              q_ready,
    input  op_e               q_op,
    input  logic [ADDR_W-1:0] q_addr,
    input  logic [DATA_W-1:0] q_wdata,
    output logic              sym_valid,
    input  logic              sym_ready,
    output sym_e              sym_kind,
    output logic [DATA_W-1:0] sym_byte,
    input  logic              done,
    input  logic              done_ack,
    input  logic [DATA_W-1:0] done_rx,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output logic [DATA_W-1:0] rsp_rdata,
    output logic              rsp_nack
);

    // one state per bus symbol, plus idle and response hold
    typedef enum logic [3:0]
    {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_WDATA,
        S_RSTART,
        S_CTRL_R,
        S_RDATA,
        S_STOP,
        S_RSP
    } state_e;

    state_e            state;
    state_e            after_done;
    op_e               op_r;
    logic [ADDR_W-1:0] addr_r;
    logic [DATA_W-1:0] wdata_r;
    logic              take;

    assign q_ready = (state == S_IDLE);
    assign take    = q_valid && q_ready;

    // where the frame goes once the current symbol finishes
    always_comb
    begin
        case (state)
            S_START:  after_done = S_CTRL_W;
            S_CTRL_W: after_done = done_ack ? S_ADDR : S_STOP;
            S_ADDR:
            begin
                if (!done_ack)
                    after_done = S_STOP;
                else if (op_r == OP_READ)
                    after_done = S_RSTART;
                else
                    after_done = S_WDATA;
            end
            S_WDATA:  after_done = S_STOP;
            S_RSTART: after_done = S_CTRL_R;
            S_CTRL_R: after_done = done_ack ? S_RDATA : S_STOP;
            S_RDATA:  after_done = S_STOP;
            S_STOP:   after_done = S_RSP;
            default:  after_done = S_IDLE;
        endcase
    end

    always_comb
    begin
        sym_byte = '0;
        case (state)
            S_START, S_RSTART: sym_kind = SYM_START;
            S_STOP:            sym_kind = SYM_STOP;
            S_RDATA:           sym_kind = SYM_RX_BYTE;
            default:           sym_kind = SYM_TX_BYTE;
        endcase
        case (state)
            S_CTRL_W: sym_byte = {DEV_CODE, addr_r[ADDR_W-1:DATA_W], 1'b0}; // write
            S_CTRL_R: sym_byte = {DEV_CODE, addr_r[ADDR_W-1:DATA_W], 1'b1}; // read
            S_ADDR:   sym_byte = addr_r[DATA_W-1:0];
            S_WDATA:  sym_byte = wdata_r;
            default:  sym_byte = '0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            sym_valid <= 1'b0;
            rsp_valid <= 1'b0;
        end
        else if (take)
        begin
            state     <= S_START;
            sym_valid <= 1'b1;
        end
        else if (state == S_RSP)
        begin
            if (rsp_ready)
            begin
                state     <= S_IDLE;
                rsp_valid <= 1'b0;
            end
        end
        else if (done)
        begin
            state     <= after_done;
            sym_valid <= (after_done != S_RSP);
            rsp_valid <= (after_done == S_RSP);
        end
        else if (sym_valid && sym_ready)
            sym_valid <= 1'b0; // engine has it, wait for done
    end

    // request copy and response payload
    always_ff @(posedge CLK)
    begin
        if (take)
        begin
            op_r      <= q_op;
            addr_r    <= q_addr;
            wdata_r   <= q_wdata;
            rsp_rdata <= '0;
            rsp_nack  <= 1'b0;
        end
        else if (done)
        begin
            if (sym_kind == SYM_TX_BYTE && !done_ack)
                rsp_nack <= 1'b1;
            if (state == S_RDATA)
                rsp_rdata <= done_rx;
        end
    end

endmodule

/* hw/eeprom_req_queue.sv */
module eeprom_req_queue
    import eeprom_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              in_valid,
    output logic              in_ready,
    input  op_e               in_op,
    input  logic [ADDR_W-1:0] in_addr,
    input  logic [DATA_W-1:0] in_wdata,
    output logic              out_valid,
    input  logic              out_ready,
    output op_e               out_op,
    output logic [ADDR_W-1:0] out_addr,
    output logic [DATA_W-1:0] out_wdata
);

    op_e               op_mem   [2];
    logic [ADDR_W-1:0] addr_mem [2];
    logic [DATA_W-1:0] data_mem [2];
    logic              wr_ptr;
    logic              rd_ptr;
    logic [1:0]        count;
    logic              push;
    logic              pop;

    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0); // visible the cycle after the write
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    assign out_op    = op_mem[rd_ptr];
    assign out_addr  = addr_mem[rd_ptr];
    assign out_wdata = data_mem[rd_ptr];

    always_ff @(posedge CLK)
    begin
        if (push)
        begin
            op_mem[wr_ptr]   <= in_op;
            addr_mem[wr_ptr] <= in_addr;
            data_mem[wr_ptr] <= in_wdata;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end
        else
        begin
            if (push)
                wr_ptr <= ~wr_ptr;
            if (pop)
                rd_ptr <= ~rd_ptr;
            count <= count + {1'b0, push} - {1'b0, pop}; // push and pop may coincide
        end
    end

endmodule

/* hw/eeprom_pkg.sv */
package eeprom_pkg;

    // address and data widths of a 16-kbit part
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    // address bits that ride in the control byte
    localparam int HI_ADDR_W = ADDR_W - DATA_W;

    localparam logic [3:0] DEV_CODE = 4'b1010; // fixed device type code

    // host request kind
    typedef enum logic
    {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } op_e;

    // one bus symbol handed to the bit engine
    // SYM_START doubles as the repeated start
    typedef enum logic [1:0]
    {
        SYM_START   = 2'd0,
        SYM_STOP    = 2'd1,
        SYM_TX_BYTE = 2'd2,
        SYM_RX_BYTE = 2'd3
    } sym_e;

endpackage
